// File: hdl/gw_pkg.sv
package gw_pkg;

  // host and flit data width
  localparam int data_width_lp = 32;

  // host register block
  localparam int host_addr_width_lp = 3;
  localparam int num_scratch_lp     = 4;
  localparam int scratch_idx_width_lp = $clog2(num_scratch_lp);
  localparam int cycle_addr_lp      = 4;

  // response fifo depth, same as the endpoint's starting credits
  localparam int resp_credits_lp      = 3;
  localparam int resp_ptr_width_lp    = $clog2(resp_credits_lp);
  localparam int resp_count_width_lp  = $clog2(resp_credits_lp + 1);

  typedef logic [resp_ptr_width_lp-1:0]   resp_ptr_t;
  typedef logic [resp_count_width_lp-1:0] resp_count_t;

  // wormhole side
  localparam int num_test_mems_lp  = 2;
  localparam int mem_addr_width_lp = 8;
  localparam int mem_words_lp      = 2 ** mem_addr_width_lp;

  // header flit fields
  localparam int wh_op_bit_lp   = 0;
  localparam int wh_len_bit_lp  = 1;
  localparam int wh_addr_lsb_lp = 2;

  typedef enum logic {
    HOST_LOAD  = 1'b0,
    HOST_STORE = 1'b1
  } host_op_e;

  typedef enum logic {
    WH_READ  = 1'b0,
    WH_WRITE = 1'b1
  } wh_op_e;

endpackage

// File: hdl/gw_host_endpoint.sv
`timescale 1ns/1ps

module gw_host_endpoint
  (input  logic                                    mc_clk_i
  ,input  logic                                    arst_n_i

  ,input  logic                                    req_v_i
  ,input  gw_pkg::host_op_e                        req_op_i
  ,input  logic [gw_pkg::host_addr_width_lp-1:0]   req_addr_i
  ,input  logic [gw_pkg::data_width_lp-1:0]        req_data_i
  ,output logic                                    req_ready_o

  ,output logic                                    resp_v_o
  ,output logic [gw_pkg::data_width_lp-1:0]        resp_data_o
  ,input  logic                                    resp_credit_i
  );

  logic [gw_pkg::data_width_lp-1:0] scratch_r [gw_pkg::num_scratch_lp];
  logic [gw_pkg::data_width_lp-1:0] cycle_r;
  logic [gw_pkg::data_width_lp-1:0] load_data;
  logic [gw_pkg::scratch_idx_width_lp-1:0] scratch_idx;
  gw_pkg::resp_count_t credits_r;
  gw_pkg::resp_count_t credits_n;
  logic req_accept;

  assign req_ready_o = (credits_r != '0);
  assign req_accept  = req_v_i & req_ready_o;
  assign scratch_idx = req_addr_i[gw_pkg::scratch_idx_width_lp-1:0];

  // read mux over the register map
  always_comb begin
    if (req_addr_i < gw_pkg::num_scratch_lp) begin
      load_data = scratch_r[scratch_idx];
    end else if (req_addr_i == gw_pkg::cycle_addr_lp) begin
      load_data = cycle_r;
    end else begin
      load_data = '0;
    end
  end

  // one credit spent per accepted request, one back per pulse
  always_comb begin
    credits_n = credits_r;
    if (req_accept) begin
      credits_n = credits_n - 1'b1;
    end
    if (resp_credit_i) begin
      credits_n = credits_n + 1'b1;
    end
  end

  always_ff @(posedge mc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits_r <= gw_pkg::resp_count_t'(gw_pkg::resp_credits_lp);
      cycle_r   <= '0;
      resp_v_o  <= 1'b0;
      for (int i = 0; i < gw_pkg::num_scratch_lp; i++) begin
        scratch_r[i] <= '0;
      end
    end else begin
      credits_r <= credits_n;
      cycle_r   <= cycle_r + 1'b1;
      resp_v_o  <= req_accept;
      if (req_accept && req_op_i == gw_pkg::HOST_STORE &&
          req_addr_i < gw_pkg::num_scratch_lp) begin
        scratch_r[scratch_idx] <= req_data_i;
      end
    end
  end

  // stores echo their data
  always_ff @(posedge mc_clk_i) begin
    if (req_accept) begin
      resp_data_o <= (req_op_i == gw_pkg::HOST_STORE) ? req_data_i : load_data;
    end
  end

endmodule

// File: hdl/gw_resp_credit_adapter.sv
`timescale 1ns/1ps

module gw_resp_credit_adapter
  (input  logic                               mc_clk_i
  ,input  logic                               arst_n_i

  ,input  logic                               resp_v_i
  ,input  logic [gw_pkg::data_width_lp-1:0]   resp_data_i
  ,output logic                               resp_credit_o

  ,output logic                               mc_resp_v_o
  ,output logic [gw_pkg::data_width_lp-1:0]   mc_resp_data_o
  ,input  logic                               mc_resp_ready_i
  );

  logic [gw_pkg::data_width_lp-1:0] fifo_mem [gw_pkg::resp_credits_lp];
  gw_pkg::resp_ptr_t   wptr_r;
  gw_pkg::resp_ptr_t   rptr_r;
  gw_pkg::resp_count_t count_r;
  logic pop;

  function automatic gw_pkg::resp_ptr_t ptr_inc(input gw_pkg::resp_ptr_t p);
    if (p == gw_pkg::resp_ptr_t'(gw_pkg::resp_credits_lp - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign mc_resp_v_o    = (count_r != '0);
  assign mc_resp_data_o = fifo_mem[rptr_r];
  assign pop            = mc_resp_v_o & mc_resp_ready_i;

  always_ff @(posedge mc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_r        <= '0;
      rptr_r        <= '0;
      count_r       <= '0;
      resp_credit_o <= 1'b0;
    end else begin
      resp_credit_o <= pop;
      if (resp_v_i) begin
        wptr_r <= ptr_inc(wptr_r);
      end
      if (pop) begin
        rptr_r <= ptr_inc(rptr_r);
      end
      if (resp_v_i && !pop) begin
        count_r <= count_r + 1'b1;
      end else if (!resp_v_i && pop) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge mc_clk_i) begin
    if (resp_v_i) begin
      fifo_mem[wptr_r] <= resp_data_i;
    end
  end

endmodule

// File: hdl/gw_wh_test_mem.sv
`timescale 1ns/1ps

module gw_wh_test_mem
  (input  logic                               mc_clk_i
  ,input  logic                               arst_n_i

  ,input  logic                               wh_v_i
  ,input  logic [gw_pkg::data_width_lp-1:0]   wh_data_i
  ,output logic                               wh_ready_o

  ,output logic                               wh_v_o
  ,output logic [gw_pkg::data_width_lp-1:0]   wh_data_o
  ,input  logic                               wh_ready_i
  );

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RECV_DATA,
    ST_REPLY_HDR,
    ST_REPLY_DATA
  } state_e;

  state_e state_r;
  state_e state_n;

  logic [gw_pkg::data_width_lp-1:0] mem [gw_pkg::mem_words_lp];
  logic [gw_pkg::data_width_lp-1:0] rdata_r;
  logic [gw_pkg::data_width_lp-1:0] reply_hdr;
  logic [gw_pkg::mem_addr_width_lp-1:0] addr_r;
  logic [gw_pkg::mem_addr_width_lp-1:0] in_addr;
  gw_pkg::wh_op_e op_r;
  gw_pkg::wh_op_e in_op;
  logic in_fire;
  logic out_fire;

  assign wh_ready_o = (state_r == ST_IDLE) || (state_r == ST_RECV_DATA);
  assign wh_v_o     = (state_r == ST_REPLY_HDR) || (state_r == ST_REPLY_DATA);
  assign in_fire    = wh_v_i & wh_ready_o;
  assign out_fire   = wh_v_o & wh_ready_i;

  assign in_op   = gw_pkg::wh_op_e'(wh_data_i[gw_pkg::wh_op_bit_lp]);
  assign in_addr = wh_data_i[gw_pkg::wh_addr_lsb_lp +: gw_pkg::mem_addr_width_lp];

  // reply header echoes op and address, len set only when data follows
  always_comb begin
    reply_hdr = '0;
    reply_hdr[gw_pkg::wh_op_bit_lp]  = op_r;
    reply_hdr[gw_pkg::wh_len_bit_lp] = (op_r == gw_pkg::WH_READ);
    reply_hdr[gw_pkg::wh_addr_lsb_lp +: gw_pkg::mem_addr_width_lp] = addr_r;
  end

  assign wh_data_o = (state_r == ST_REPLY_DATA) ? rdata_r : reply_hdr;

  always_comb begin
    state_n = state_r;
    case (state_r)
      ST_IDLE: begin
        if (in_fire) begin
          state_n = wh_data_i[gw_pkg::wh_len_bit_lp] ? ST_RECV_DATA : ST_REPLY_HDR;
        end
      end
      ST_RECV_DATA: begin
        if (in_fire) begin
          state_n = ST_REPLY_HDR;
        end
      end
      ST_REPLY_HDR: begin
        if (out_fire) begin
          state_n = (op_r == gw_pkg::WH_READ) ? ST_REPLY_DATA : ST_IDLE;
        end
      end
      ST_REPLY_DATA: begin
        if (out_fire) begin
          state_n = ST_IDLE;
        end
      end
      default: state_n = ST_IDLE;
    endcase
  end

  always_ff @(posedge mc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= ST_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  // header fields and read data are captured when the header lands
  always_ff @(posedge mc_clk_i) begin
    if (in_fire && state_r == ST_IDLE) begin
      op_r    <= in_op;
      addr_r  <= in_addr;
      rdata_r <= mem[in_addr];
    end
    if (in_fire && state_r == ST_RECV_DATA && op_r == gw_pkg::WH_WRITE) begin
      mem[addr_r] <= wh_data_i;
    end
  end

endmodule

// File: hdl/gw_core_complex.sv
`timescale 1ns/1ps

module gw_core_complex
  (input  logic                                         mc_clk_i
  ,input  logic                                         arst_n_i

  // host request link
  ,input  logic                                         mc_req_v_i
  ,input  gw_pkg::host_op_e                             mc_req_op_i
  ,input  logic [gw_pkg::host_addr_width_lp-1:0]        mc_req_addr_i
  ,input  logic [gw_pkg::data_width_lp-1:0]             mc_req_data_i
  ,output logic                                         mc_req_ready_o

  // host response link
  ,output logic                                         mc_resp_v_o
  ,output logic [gw_pkg::data_width_lp-1:0]             mc_resp_data_o
  ,input  logic                                         mc_resp_ready_i

  // wormhole links
  ,input  logic [gw_pkg::num_test_mems_lp-1:0]                             wh_v_i
  ,input  logic [gw_pkg::num_test_mems_lp-1:0][gw_pkg::data_width_lp-1:0]  wh_data_i
  ,output logic [gw_pkg::num_test_mems_lp-1:0]                             wh_ready_o
  ,output logic [gw_pkg::num_test_mems_lp-1:0]                             wh_v_o
  ,output logic [gw_pkg::num_test_mems_lp-1:0][gw_pkg::data_width_lp-1:0]  wh_data_o
  ,input  logic [gw_pkg::num_test_mems_lp-1:0]                             wh_ready_i
  );

  logic                             resp_v;
  logic [gw_pkg::data_width_lp-1:0] resp_data;
  logic                             resp_credit;

  gw_host_endpoint host
    (.mc_clk_i      (mc_clk_i)
    ,.arst_n_i      (arst_n_i)
    ,.req_v_i       (mc_req_v_i)
    ,.req_op_i      (mc_req_op_i)
    ,.req_addr_i    (mc_req_addr_i)
    ,.req_data_i    (mc_req_data_i)
    ,.req_ready_o   (mc_req_ready_o)
    ,.resp_v_o      (resp_v)
    ,.resp_data_o   (resp_data)
    ,.resp_credit_i (resp_credit)
    );

  // credit side back to ready/valid
  gw_resp_credit_adapter resp_adapter
    (.mc_clk_i        (mc_clk_i)
    ,.arst_n_i        (arst_n_i)
    ,.resp_v_i        (resp_v)
    ,.resp_data_i     (resp_data)
    ,.resp_credit_o   (resp_credit)
    ,.mc_resp_v_o     (mc_resp_v_o)
    ,.mc_resp_data_o  (mc_resp_data_o)
    ,.mc_resp_ready_i (mc_resp_ready_i)
    );

  for (genvar i = 0; i < gw_pkg::num_test_mems_lp; i++) begin : link
    gw_wh_test_mem test_mem
      (.mc_clk_i   (mc_clk_i)
      ,.arst_n_i   (arst_n_i)
      ,.wh_v_i     (wh_v_i[i])
      ,.wh_data_i  (wh_data_i[i])
      ,.wh_ready_o (wh_ready_o[i])
      ,.wh_v_o     (wh_v_o[i])
      ,.wh_data_o  (wh_data_o[i])
      ,.wh_ready_i (wh_ready_i[i])
      );
  end

endmodule

// File: tb/gw_core_complex_properties.sv
`timescale 1ns/1ps

module gw_core_complex_properties
  (input logic                               mc_clk_i
  ,input logic                               arst_n_i
  ,input logic                               resp_v_i
  ,input logic                               credit_i
  ,input gw_pkg::resp_count_t                count_i
  ,input logic                               out_v_i
  ,input logic [gw_pkg::data_width_lp-1:0]   out_data_i
  ,input logic                               out_ready_i
  );

  // entries held, in flight or awaiting their credit stay within the credits
  credit_bound: assert property (@(posedge mc_clk_i) disable iff (!arst_n_i)
    int'(count_i) + int'(resp_v_i) + int'(credit_i) <= gw_pkg::resp_credits_lp)
    else $error("endpoint sent a response without a free credit");

  // a write into a full fifo needs a pop on the same edge
  no_overflow: assert property (@(posedge mc_clk_i) disable iff (!arst_n_i)
    resp_v_i && count_i == gw_pkg::resp_credits_lp |-> out_v_i && out_ready_i)
    else $error("response written while the fifo is full");

  resp_hold: assert property (@(posedge mc_clk_i) disable iff (!arst_n_i)
    out_v_i && !out_ready_i |=> out_v_i && $stable(out_data_i))
    else $error("host response dropped or changed before it was accepted");

endmodule

bind gw_resp_credit_adapter gw_core_complex_properties props
  (.mc_clk_i    (mc_clk_i)
  ,.arst_n_i    (arst_n_i)
  ,.resp_v_i    (resp_v_i)
  ,.credit_i    (resp_credit_o)
  ,.count_i     (count_r)
  ,.out_v_i     (mc_resp_v_o)
  ,.out_data_i  (mc_resp_data_o)
  ,.out_ready_i (mc_resp_ready_i)
  );

// File: tb/tb_gw_core_complex.sv
`timescale 1ns/1ps

module tb_gw_core_complex;

  localparam int seed_lp    = 32'h1b5a492a;
  // 200 host ops and 400 packets with random stalls stay far below this
  localparam int timeout_lp = 20000;
  localparam int links_lp   = gw_pkg::num_test_mems_lp;
  localparam int words_lp   = 2 ** gw_pkg::mem_addr_width_lp;

  typedef logic [gw_pkg::data_width_lp-1:0] word_t;

  logic                                  mc_clk_i = 1'b0;
  logic                                  arst_n_i;
  logic                                  mc_req_v_i;
  gw_pkg::host_op_e                      mc_req_op_i;
  logic [gw_pkg::host_addr_width_lp-1:0] mc_req_addr_i;
  word_t                                 mc_req_data_i;
  logic                                  mc_req_ready_o;
  logic                                  mc_resp_v_o;
  word_t                                 mc_resp_data_o;
  logic                                  mc_resp_ready_i;
  logic [links_lp-1:0]                   wh_v_i;
  logic [links_lp-1:0][gw_pkg::data_width_lp-1:0] wh_data_i;
  logic [links_lp-1:0]                   wh_ready_o;
  logic [links_lp-1:0]                   wh_v_o;
  logic [links_lp-1:0][gw_pkg::data_width_lp-1:0] wh_data_o;
  logic [links_lp-1:0]                   wh_ready_i;

  // reference model
  word_t scratch_m [gw_pkg::num_scratch_lp];
  word_t mem_m [links_lp][words_lp];
  bit    mem_ok [links_lp][words_lp];
  bit    any_written [links_lp];
  word_t host_q [$];

  // per link packet progress
  word_t req_flit [links_lp][2];
  word_t exp_flit [links_lp][2];
  int    req_len [links_lp];
  int    sent [links_lp];
  int    exp_cnt [links_lp];
  int    exp_idx [links_lp];
  int    pkts_left [links_lp];
  bit    in_fire [links_lp];
  bit    out_fire [links_lp];
  logic [links_lp-1:0] active;

  int errors    = 0;
  int npass     = 0;
  int nfail     = 0;
  int cycle_cnt = 0;

  gw_core_complex uut
    (.mc_clk_i        (mc_clk_i)
    ,.arst_n_i        (arst_n_i)
    ,.mc_req_v_i      (mc_req_v_i)
    ,.mc_req_op_i     (mc_req_op_i)
    ,.mc_req_addr_i   (mc_req_addr_i)
    ,.mc_req_data_i   (mc_req_data_i)
    ,.mc_req_ready_o  (mc_req_ready_o)
    ,.mc_resp_v_o     (mc_resp_v_o)
    ,.mc_resp_data_o  (mc_resp_data_o)
    ,.mc_resp_ready_i (mc_resp_ready_i)
    ,.wh_v_i          (wh_v_i)
    ,.wh_data_i       (wh_data_i)
    ,.wh_ready_o      (wh_ready_o)
    ,.wh_v_o          (wh_v_o)
    ,.wh_data_o       (wh_data_o)
    ,.wh_ready_i      (wh_ready_i)
    );

  always #4 mc_clk_i = ~mc_clk_i;

  always @(posedge mc_clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_lp) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_lp);
      $display("Test failed");
      $finish;
    end
  end

  // stores echo data, scratch loads return the last store, the rest read zero
  function automatic word_t host_expect(gw_pkg::host_op_e op, int addr, word_t data);
    word_t exp;
    exp = '0;
    if (op == gw_pkg::HOST_STORE) begin
      exp = data;
      if (addr < gw_pkg::num_scratch_lp) scratch_m[addr] = data;
    end else if (addr < gw_pkg::num_scratch_lp) begin
      exp = scratch_m[addr];
    end
    return exp;
  endfunction

  function automatic word_t mk_hdr(logic op, logic len, int addr);
    word_t h;
    h = '0;
    h[gw_pkg::wh_op_bit_lp]  = op;
    h[gw_pkg::wh_len_bit_lp] = len;
    h[gw_pkg::wh_addr_lsb_lp +: gw_pkg::mem_addr_width_lp] =
      addr[gw_pkg::mem_addr_width_lp-1:0];
    return h;
  endfunction

  task automatic tick();
    @(negedge mc_clk_i);
  endtask

  task automatic mismatch(string name, word_t got, word_t exp);
    $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    errors++;
  endtask

  task automatic problem(string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  task automatic finish_test(string name, int err_start);
    if (errors == err_start) begin
      npass++;
      $display("test %s: pass", name);
    end else begin
      nfail++;
      $display("test %s: FAIL with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic host_send(gw_pkg::host_op_e op, int addr, word_t data);
    mc_req_v_i    = 1'b1;
    mc_req_op_i   = op;
    mc_req_addr_i = addr[gw_pkg::host_addr_width_lp-1:0];
    mc_req_data_i = data;
    while (!mc_req_ready_o) tick();
    tick();
    mc_req_v_i = 1'b0;
  endtask

  // expects mc_resp_ready_i high
  task automatic host_recv(output word_t data);
    while (!mc_resp_v_o) tick();
    data = mc_resp_data_o;
    tick();
  endtask

  task automatic drive_scratch_req();
    mc_req_op_i   = gw_pkg::host_op_e'($urandom % 2);
    mc_req_addr_i = 3'($urandom % gw_pkg::num_scratch_lp);
    mc_req_data_i = $urandom;
  endtask

  task automatic new_packet(int l);
    int    a;
    bit    wr;
    word_t d;
    a  = $urandom % words_lp;
    d  = $urandom;
    wr = !any_written[l] || ($urandom % 2 == 1);
    pkts_left[l]--;
    active[l]  = 1'b1;
    sent[l]    = 0;
    exp_idx[l] = 0;
    if (wr) begin
      req_flit[l][0] = mk_hdr(gw_pkg::WH_WRITE, 1'b1, a);
      req_flit[l][1] = d;
      req_len[l]     = 2;
      exp_flit[l][0] = mk_hdr(gw_pkg::WH_WRITE, 1'b0, a);
      exp_cnt[l]     = 1;
      mem_m[l][a]    = d;
      mem_ok[l][a]   = 1'b1;
      any_written[l] = 1'b1;
    end else begin
      // only read back words this link has written
      while (!mem_ok[l][a]) a = (a + 1) % words_lp;
      req_flit[l][0] = mk_hdr(gw_pkg::WH_READ, 1'b0, a);
      req_len[l]     = 1;
      exp_flit[l][0] = mk_hdr(gw_pkg::WH_READ, 1'b1, a);
      exp_flit[l][1] = mem_m[l][a];
      exp_cnt[l]     = 2;
    end
  endtask

  task automatic link_step(int l, bit stall);
    // account for transfers on the edge just passed
    if (in_fire[l]) sent[l]++;
    if (out_fire[l]) exp_idx[l]++;
    if (active[l] && sent[l] == req_len[l] && exp_idx[l] == exp_cnt[l]) begin
      if (pkts_left[l] > 0) new_packet(l);
      else active[l] = 1'b0;
    end
    if (active[l] && sent[l] < req_len[l]) begin
      if (!wh_v_i[l] || in_fire[l]) wh_v_i[l] = stall ? ($urandom % 4 != 0) : 1'b1;
      wh_data_i[l] = req_flit[l][sent[l]];
    end else begin
      wh_v_i[l] = 1'b0;
      if (active[l] && wh_ready_o[l])
        problem($sformatf("link %0d takes request flits while its reply is pending", l));
    end
    wh_ready_i[l] = stall ? ($urandom % 2 == 1) : 1'b1;
    in_fire[l]    = wh_v_i[l] && wh_ready_o[l];
    out_fire[l]   = wh_v_o[l] && wh_ready_i[l];
    if (out_fire[l]) begin
      if (!active[l] || sent[l] < req_len[l])
        problem($sformatf("link %0d sent a reply flit with no request", l));
      else if (wh_data_o[l] !== exp_flit[l][exp_idx[l]])
        mismatch($sformatf("wh_data_o[%0d]", l), wh_data_o[l], exp_flit[l][exp_idx[l]]);
    end
  endtask

  task automatic wh_run(int npkts, bit stall);
    for (int l = 0; l < links_lp; l++) begin
      pkts_left[l] = npkts;
      in_fire[l]   = 1'b0;
      out_fire[l]  = 1'b0;
      new_packet(l);
    end
    while (active != '0) begin
      for (int l = 0; l < links_lp; l++) link_step(l, stall);
      tick();
    end
    wh_v_i     = '0;
    wh_ready_i = '1;
  endtask

  initial begin
    word_t got;
    word_t exp;
    word_t prev;
    word_t data;
    int    addr;
    int    err_start;
    int    accepted;
    gw_pkg::host_op_e op;

    void'($urandom(seed_lp));
    arst_n_i        = 1'b0;
    mc_req_v_i      = 1'b0;
    mc_req_op_i     = gw_pkg::HOST_LOAD;
    mc_req_addr_i   = '0;
    mc_req_data_i   = '0;
    mc_resp_ready_i = 1'b1;
    wh_v_i          = '0;
    wh_data_i       = '0;
    wh_ready_i      = '1;
    active          = '0;
    for (int i = 0; i < gw_pkg::num_scratch_lp; i++) scratch_m[i] = '0;
    repeat (2) tick();
    arst_n_i = 1'b1;

    err_start = errors;
    if (mc_resp_v_o !== 1'b0) mismatch("mc_resp_v_o", 32'(mc_resp_v_o), 0);
    if (wh_v_o !== '0) mismatch("wh_v_o", 32'(wh_v_o), 0);
    if (mc_req_ready_o !== 1'b1) mismatch("mc_req_ready_o", 32'(mc_req_ready_o), 1);
    if (wh_ready_o !== '1) mismatch("wh_ready_o", 32'(wh_ready_o), 3);
    finish_test("reset_state", err_start);

    err_start = errors;
    for (int i = 0; i < 120; i++) begin
      op   = gw_pkg::host_op_e'($urandom % 2);
      addr = $urandom % 7;
      if (addr >= gw_pkg::cycle_addr_lp) addr++;
      data = $urandom;
      exp  = host_expect(op, addr, data);
      host_send(op, addr, data);
      host_recv(got);
      if (got !== exp) mismatch("mc_resp_data_o", got, exp);
    end
    finish_test("scratch_registers", err_start);

    err_start = errors;
    prev = '0;
    for (int i = 0; i < 12; i++) begin
      if (i == 6) begin
        data = $urandom;
        host_send(gw_pkg::HOST_STORE, gw_pkg::cycle_addr_lp, data);
        host_recv(got);
        if (got !== data) mismatch("mc_resp_data_o", got, data);
      end
      host_send(gw_pkg::HOST_LOAD, gw_pkg::cycle_addr_lp, '0);
      host_recv(got);
      if (i > 0 && got <= prev)
        mismatch("mc_resp_data_o (cycle count not above previous)", got, prev);
      prev = got;
    end
    finish_test("cycle_counter", err_start);

    err_start = errors;
    mc_resp_ready_i = 1'b0;
    accepted        = 0;
    mc_req_v_i      = 1'b1;
    drive_scratch_req();
    repeat (12) begin
      if (mc_req_ready_o) begin
        host_q.push_back(host_expect(mc_req_op_i, mc_req_addr_i, mc_req_data_i));
        accepted++;
        tick();
        drive_scratch_req();
      end else begin
        tick();
      end
    end
    mc_req_v_i = 1'b0;
    if (accepted != gw_pkg::resp_credits_lp)
      mismatch("accepted request count", accepted, gw_pkg::resp_credits_lp);
    if (mc_req_ready_o !== 1'b0) mismatch("mc_req_ready_o", 32'(mc_req_ready_o), 0);
    while (host_q.size() > 0) begin
      mc_resp_ready_i = ($urandom % 2 == 1);
      if (mc_resp_v_o && mc_resp_ready_i) begin
        exp = host_q.pop_front();
        if (mc_resp_data_o !== exp) mismatch("mc_resp_data_o", mc_resp_data_o, exp);
      end
      tick();
    end
    mc_resp_ready_i = 1'b1;
    if (mc_resp_v_o) problem("host response link still valid after the last expected response");
    finish_test("host_backpressure", err_start);

    err_start = errors;
    wh_run(100, 1'b0);
    finish_test("wormhole_write_read", err_start);

    err_start = errors;
    wh_run(100, 1'b1);
    finish_test("wormhole_backpressure", err_start);

    $display("summary: %0d passed, %0d failed", npass, nfail);
    if (nfail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: files.f
hdl/gw_pkg.sv
hdl/gw_host_endpoint.sv
hdl/gw_resp_credit_adapter.sv
hdl/gw_wh_test_mem.sv
hdl/gw_core_complex.sv
tb/gw_core_complex_properties.sv
tb/tb_gw_core_complex.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gw_core_complex -f files.f -o sim_gw

# a failed assertion stops the model with a nonzero status
if ! ./obj_dir/sim_gw > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
